/* source/cache_cfg_pkg.sv */
// cache system configuration
// address, data, line and tag vector types
// default sizes for banks, lines and backing store

`default_nettype none

package cache_cfg_pkg;

  // ----------------------------------------
  // vector types
  // ----------------------------------------

  // byte address
  typedef logic [31:0]  addr_t;
  // one data word
  typedef logic [31:0]  word_t;
  // full cache line, four words
  typedef logic [127:0] line_t;
  // requester tag, echoed back untouched
  typedef logic [7:0]   opaque_t;

  // ----------------------------------------
  // sizes
  // ----------------------------------------

  localparam int unsigned WORDS_PER_LINE = 4;

  // defaults, top level passes these down
  localparam int unsigned DEF_NUM_BANKS          = 4;
  localparam int unsigned DEF_LINES_PER_BANK     = 16;
  // 64 lines x 16 B x 4 banks gives 4 KB
  localparam int unsigned DEF_MEM_LINES_PER_BANK = 64;
  // cycles per backing access
  localparam int unsigned DEF_MEM_LATENCY        = 4;

endpackage

`default_nettype wire

/* source/cache_msg_pkg.sv */
// memory message encoding
// request and response type field

`default_nettype none

package cache_msg_pkg;

  // same codes on requests and responses
  // write-init behaves as a write inside the cache
  typedef enum logic [1:0]
  {
    msg_read       = 2'd0,
    msg_write      = 2'd1,
    msg_write_init = 2'd2
  } msg_type_e;

endpackage

`default_nettype wire

/* source/bank_req_if.sv */
// request channel from router to one bank
// val/rdy handshake with full request payload

`timescale 1ns/100ps
`default_nettype none

interface bank_req_if
  import cache_cfg_pkg::*, cache_msg_pkg::*;
();

  // handshake
  logic      val;
  logic      rdy;

  // payload, held stable while val is high
  msg_type_e msg_type;
  opaque_t   opaque;
  addr_t     addr;
  word_t     data;

  // router side sends the request
  modport router (output val, msg_type, opaque, addr, data, input rdy);

  // bank side takes it when idle
  modport bank (input val, msg_type, opaque, addr, data, output rdy);

endinterface

`default_nettype wire

/* source/bank_resp_if.sv */
// response channel from one bank to the arbiter
// val/rdy handshake with response payload

`timescale 1ns/100ps
`default_nettype none

interface bank_resp_if
  import cache_cfg_pkg::*, cache_msg_pkg::*;
();

  logic      val;
  logic      rdy;

  // type and opaque copied from the request
  msg_type_e msg_type;
  opaque_t   opaque;
  // read data, zero for writes
  word_t     data;

  modport bank (output val, msg_type, opaque, data, input rdy);

  // arbiter grants one bank at a time
  modport arbiter (input val, msg_type, opaque, data, output rdy);

endinterface

`default_nettype wire

/* source/cache_req_router.sv */
// request router
// one-entry holding register for accepted requests
// bank decode from address and per-bank val steering

`timescale 1ns/100ps
`default_nettype none

module cache_req_router
  import cache_cfg_pkg::*, cache_msg_pkg::*;
#(
  parameter int unsigned NUM_BANKS = DEF_NUM_BANKS
)
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       cachereq_val,
  output      logic       cachereq_rdy,
  input  wire msg_type_e  cachereq_type,
  input  wire opaque_t    cachereq_opaque,
  input  wire addr_t      cachereq_addr,
  input  wire word_t      cachereq_data,
  bank_req_if.router      bank_req [NUM_BANKS]
);

  localparam int unsigned SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  logic                 held_val;
  msg_type_e            held_type;
  opaque_t              held_opaque;
  addr_t                held_addr;
  word_t                held_data;
  logic [SEL_W-1:0]     bank_sel;
  logic [NUM_BANKS-1:0] bank_rdy;
  logic                 taken;

  // bank bits sit just above the line offset
  assign bank_sel = SEL_W'((held_addr >> 4) & addr_t'(NUM_BANKS - 1));

  // only take a new request into an empty register
  assign cachereq_rdy = !held_val;
  assign taken        = held_val && bank_rdy[bank_sel];

  // ----------------------------------------
  // steering
  // ----------------------------------------
  for (genvar g = 0; g < NUM_BANKS; g++)
  begin : g_bank
    // payload fans out to every bank, val to one
    assign bank_req[g].val      = held_val && (bank_sel == SEL_W'(g));
    assign bank_req[g].msg_type = held_type;
    assign bank_req[g].opaque   = held_opaque;
    assign bank_req[g].addr     = held_addr;
    assign bank_req[g].data     = held_data;
    assign bank_rdy[g]          = bank_req[g].rdy;
  end

  // occupancy of the holding register
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      held_val <= 1'b0;
    else if (cachereq_val && cachereq_rdy)
      held_val <= 1'b1;
    else if (taken)
      held_val <= 1'b0;
  end

  // request payload, full address kept
  always_ff @(posedge clk)
  begin
    if (cachereq_val && cachereq_rdy)
    begin
      held_type   <= cachereq_type;
      held_opaque <= cachereq_opaque;
      held_addr   <= cachereq_addr;
      held_data   <= cachereq_data;
    end
  end

endmodule

`default_nettype wire

/* source/cache_bank.sv */
// one cache bank
// direct-mapped, write-back, write-allocate
// tag, valid and dirty state, line storage
// backing store with fixed access latency

`timescale 1ns/100ps
`default_nettype none

module cache_bank
  import cache_cfg_pkg::*, cache_msg_pkg::*;
#(
  parameter int unsigned NUM_BANKS          = DEF_NUM_BANKS,
  parameter int unsigned LINES_PER_BANK     = DEF_LINES_PER_BANK,
  parameter int unsigned MEM_LINES_PER_BANK = DEF_MEM_LINES_PER_BANK,
  parameter int unsigned MEM_LATENCY        = DEF_MEM_LATENCY
)
(
  input  wire logic clk,
  input  wire logic rst_n,
  bank_req_if.bank  req,
  bank_resp_if.bank resp
);

  // ----------------------------------------
  // address fields
  // ----------------------------------------
  localparam int unsigned OFF_W      = $clog2(WORDS_PER_LINE);
  localparam int unsigned BANK_W     = $clog2(NUM_BANKS);
  // byte offset, word offset, bank bits all dropped
  localparam int unsigned LINE_SHIFT = 2 + OFF_W + BANK_W;
  localparam int unsigned IDX_W      = (LINES_PER_BANK > 1) ? $clog2(LINES_PER_BANK) : 1;
  localparam int unsigned MEM_W      = (MEM_LINES_PER_BANK > 1) ?
                                       $clog2(MEM_LINES_PER_BANK) : 1;
  localparam int unsigned TAG_W      = (MEM_W > IDX_W) ? MEM_W - IDX_W : 1;
  localparam int unsigned CNT_W      = $clog2(MEM_LATENCY + 1);

  typedef logic [OFF_W-1:0] offset_t;
  typedef logic [IDX_W-1:0] index_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [MEM_W-1:0] mem_line_t;
  typedef logic [CNT_W-1:0] cnt_t;

  typedef enum logic [2:0]
  {
    st_idle,
    st_tag_check,
    st_writeback,
    st_refill,
    st_respond
  } state_e;

  localparam cnt_t LAT_LOAD = cnt_t'(MEM_LATENCY - 1);

  // word select helpers
  function automatic word_t get_word(line_t line, offset_t off);
    return line[off * $bits(word_t) +: $bits(word_t)];
  endfunction

  function automatic line_t put_word(line_t line, offset_t off, word_t w);
    line_t res;
    res = line;
    res[off * $bits(word_t) +: $bits(word_t)] = w;
    return res;
  endfunction

  state_e                    state;
  cnt_t                      cnt;
  logic [LINES_PER_BANK-1:0] valid_bits;
  logic [LINES_PER_BANK-1:0] dirty_bits;

  // storage, no reset
  tag_t  tag_array  [LINES_PER_BANK];
  line_t data_array [LINES_PER_BANK];
  line_t backing    [MEM_LINES_PER_BANK];

  // request currently in service
  msg_type_e cur_type;
  opaque_t   cur_opaque;
  index_t    cur_index;
  tag_t      cur_tag;
  offset_t   cur_off;
  word_t     cur_data;
  word_t     resp_word;

  mem_line_t in_line;
  line_t     cur_line;
  line_t     fill_line;
  mem_line_t victim_addr;
  mem_line_t fill_addr;
  logic      hit;
  logic      victim_dirty;
  logic      is_write;
  logic      accept;

  // bank-local line number, bank bits removed
  assign in_line = mem_line_t'(req.addr >> LINE_SHIFT);
  assign accept  = (state == st_idle) && req.val;

  assign cur_line     = data_array[cur_index];
  assign hit          = valid_bits[cur_index] && (tag_array[cur_index] == cur_tag);
  assign victim_dirty = valid_bits[cur_index] && dirty_bits[cur_index];
  // write-init is a plain write here
  assign is_write     = (cur_type != msg_read);

  // backing store line numbers
  assign victim_addr = mem_line_t'({tag_array[cur_index], cur_index});
  assign fill_addr   = mem_line_t'({cur_tag, cur_index});
  assign fill_line   = backing[fill_addr];

  // handshakes
  assign req.rdy       = (state == st_idle);
  assign resp.val      = (state == st_respond);
  assign resp.msg_type = cur_type;
  assign resp.opaque   = cur_opaque;
  assign resp.data     = resp_word;

  // ----------------------------------------
  // control fsm
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state      <= st_idle;
      cnt        <= '0;
      valid_bits <= '0;
      dirty_bits <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (req.val)
            state <= st_tag_check;
        end
        st_tag_check:
        begin
          if (hit)
          begin
            if (is_write)
              dirty_bits[cur_index] <= 1'b1;
            state <= st_respond;
          end
          else
          begin
            // dirty victim goes out before the refill
            state <= victim_dirty ? st_writeback : st_refill;
            cnt   <= LAT_LOAD;
          end
        end
        st_writeback:
        begin
          if (cnt == '0)
          begin
            state <= st_refill;
            cnt   <= LAT_LOAD;
          end
          else
            cnt <= cnt - 1'b1;
        end
        st_refill:
        begin
          if (cnt == '0)
          begin
            valid_bits[cur_index] <= 1'b1;
            dirty_bits[cur_index] <= is_write;
            state                 <= st_respond;
          end
          else
            cnt <= cnt - 1'b1;
        end
        st_respond:
        begin
          // next request only after this response is gone
          if (resp.rdy)
            state <= st_idle;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------
  // datapath and storage
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cur_type   <= req.msg_type;
      cur_opaque <= req.opaque;
      cur_index  <= index_t'(in_line);
      cur_tag    <= tag_t'(in_line >> IDX_W);
      cur_off    <= offset_t'(req.addr >> 2);
      cur_data   <= req.data;
    end

    // hit, access the resident line
    if (state == st_tag_check && hit)
    begin
      if (is_write)
      begin
        data_array[cur_index] <= put_word(cur_line, cur_off, cur_data);
        resp_word             <= '0;
      end
      else
        resp_word <= get_word(cur_line, cur_off);
    end

    // victim out at the end of the writeback delay
    if (state == st_writeback && cnt == '0)
      backing[victim_addr] <= cur_line;

    // refill merged with the pending access
    if (state == st_refill && cnt == '0)
    begin
      tag_array[cur_index] <= cur_tag;
      if (is_write)
      begin
        data_array[cur_index] <= put_word(fill_line, cur_off, cur_data);
        resp_word             <= '0;
      end
      else
      begin
        data_array[cur_index] <= fill_line;
        resp_word             <= get_word(fill_line, cur_off);
      end
    end
  end

endmodule

`default_nettype wire

/* source/cache_resp_arbiter.sv */
// response arbiter
// round-robin pick among banks with a response ready
// single output register toward the requester

`timescale 1ns/100ps
`default_nettype none

module cache_resp_arbiter
  import cache_cfg_pkg::*, cache_msg_pkg::*;
#(
  parameter int unsigned NUM_BANKS = DEF_NUM_BANKS
)
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  bank_resp_if.arbiter   bank_resp [NUM_BANKS],
  output      logic      cacheresp_val,
  input  wire logic      cacheresp_rdy,
  output      msg_type_e cacheresp_type,
  output      opaque_t   cacheresp_opaque,
  output      word_t     cacheresp_data
);

  localparam int unsigned SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  logic [NUM_BANKS-1:0] resp_val;
  msg_type_e            resp_type   [NUM_BANKS];
  opaque_t              resp_opaque [NUM_BANKS];
  word_t                resp_data   [NUM_BANKS];
  logic [SEL_W-1:0]     ptr;
  logic [SEL_W-1:0]     winner;
  logic                 any_val;
  logic                 load_en;
  logic                 grant;

  // register free, or emptying this cycle
  assign load_en = !cacheresp_val || cacheresp_rdy;
  assign any_val = |resp_val;
  assign grant   = load_en && any_val;

  // ----------------------------------------
  // gather bank responses, grant one
  // ----------------------------------------
  for (genvar g = 0; g < NUM_BANKS; g++)
  begin : g_bank
    assign resp_val[g]     = bank_resp[g].val;
    assign resp_type[g]    = bank_resp[g].msg_type;
    assign resp_opaque[g]  = bank_resp[g].opaque;
    assign resp_data[g]    = bank_resp[g].data;
    assign bank_resp[g].rdy = grant && (winner == SEL_W'(g));
  end

  // first valid bank at or after the pointer
  always_comb
  begin
    winner = ptr;
    // walk backwards so the nearest one wins
    for (int k = NUM_BANKS - 1; k >= 0; k--)
    begin
      if (resp_val[(int'(ptr) + k) % NUM_BANKS])
        winner = SEL_W'((int'(ptr) + k) % NUM_BANKS);
    end
  end

  // valid bit and round-robin pointer
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cacheresp_val <= 1'b0;
      ptr           <= '0;
    end
    else if (load_en)
    begin
      cacheresp_val <= any_val;
      // winner drops to lowest priority
      if (any_val)
        ptr <= SEL_W'(winner + 1'b1);
    end
  end

  // output payload
  always_ff @(posedge clk)
  begin
    if (grant)
    begin
      cacheresp_type   <= resp_type[winner];
      cacheresp_opaque <= resp_opaque[winner];
      cacheresp_data   <= resp_data[winner];
    end
  end

endmodule

`default_nettype wire

/* source/banked_cache_top.sv */
// banked cache top level
// request router, generated banks, response arbiter
// plain val/rdy ports toward the requester

`timescale 1ns/100ps
`default_nettype none

module banked_cache_top
  import cache_cfg_pkg::*, cache_msg_pkg::*;
#(
  parameter int unsigned NUM_BANKS          = DEF_NUM_BANKS,
  parameter int unsigned LINES_PER_BANK     = DEF_LINES_PER_BANK,
  parameter int unsigned MEM_LINES_PER_BANK = DEF_MEM_LINES_PER_BANK,
  parameter int unsigned MEM_LATENCY        = DEF_MEM_LATENCY
)
(
  input  wire logic      clk,
  input  wire logic      rst_n,

  // request side
  input  wire logic      cachereq_val,
  output      logic      cachereq_rdy,
  input  wire msg_type_e cachereq_type,
  input  wire opaque_t   cachereq_opaque,
  input  wire addr_t     cachereq_addr,
  input  wire word_t     cachereq_data,

  // response side
  output      logic      cacheresp_val,
  input  wire logic      cacheresp_rdy,
  output      msg_type_e cacheresp_type,
  output      opaque_t   cacheresp_opaque,
  output      word_t     cacheresp_data
);

  // one channel pair per bank
  bank_req_if  bank_req  [NUM_BANKS] ();
  bank_resp_if bank_resp [NUM_BANKS] ();

  cache_req_router #(
    .NUM_BANKS (NUM_BANKS)
  ) cache_req_router_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .cachereq_val    (cachereq_val),
    .cachereq_rdy    (cachereq_rdy),
    .cachereq_type   (cachereq_type),
    .cachereq_opaque (cachereq_opaque),
    .cachereq_addr   (cachereq_addr),
    .cachereq_data   (cachereq_data),
    .bank_req        (bank_req)
  );

  // ----------------------------------------
  // banks
  // ----------------------------------------
  for (genvar g = 0; g < NUM_BANKS; g++)
  begin : g_bank
    cache_bank #(
      .NUM_BANKS          (NUM_BANKS),
      .LINES_PER_BANK     (LINES_PER_BANK),
      .MEM_LINES_PER_BANK (MEM_LINES_PER_BANK),
      .MEM_LATENCY        (MEM_LATENCY)
    ) cache_bank_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (bank_req[g]),
      .resp  (bank_resp[g])
    );
  end

  cache_resp_arbiter #(
    .NUM_BANKS (NUM_BANKS)
  ) cache_resp_arbiter_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .bank_resp        (bank_resp),
    .cacheresp_val    (cacheresp_val),
    .cacheresp_rdy    (cacheresp_rdy),
    .cacheresp_type   (cacheresp_type),
    .cacheresp_opaque (cacheresp_opaque),
    .cacheresp_data   (cacheresp_data)
  );

endmodule

`default_nettype wire

/* dv/banked_cache_tb.sv */
// testbench for the banked cache
// clock, reset, directed and random stimulus
// reference model, outstanding table, assertions, watchdog

`timescale 1ns/100ps
`default_nettype none

module banked_cache_tb
  import cache_cfg_pkg::*, cache_msg_pkg::*;
();

  localparam logic [31:0] SEED       = 32'hef393f6e;
  localparam int          CLK_PERIOD = 8;
  localparam int          N_DIRECTED = 16;
  localparam int          N_RANDOM   = 300;
  // per-request budget covers writeback and refill plus slack
  localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * (2 * DEF_MEM_LATENCY + 20);

  logic      clk = 1'b0;
  logic      rst_n;
  logic      cachereq_val;
  logic      cachereq_rdy;
  msg_type_e cachereq_type;
  opaque_t   cachereq_opaque;
  addr_t     cachereq_addr;
  word_t     cachereq_data;
  logic      cacheresp_val;
  logic      cacheresp_rdy = 1'b1;
  msg_type_e cacheresp_type;
  opaque_t   cacheresp_opaque;
  word_t     cacheresp_data;

  int        errors = 0;
  logic      bp_on  = 1'b0;
  opaque_t   next_opaque;
  // reference memory keyed by word address bits 11..2
  word_t     model [logic [9:0]];
  // outstanding requests keyed by opaque tag
  logic      pend_valid [256];
  msg_type_e pend_type  [256];
  word_t     pend_data  [256];
  logic [9:0] written [$];

  logic      resp_fire;
  logic      exp_valid;
  msg_type_e exp_type;
  word_t     exp_data;

  always #(CLK_PERIOD / 2) clk = ~clk;

  banked_cache_top banked_cache_top_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .cachereq_val     (cachereq_val),
    .cachereq_rdy     (cachereq_rdy),
    .cachereq_type    (cachereq_type),
    .cachereq_opaque  (cachereq_opaque),
    .cachereq_addr    (cachereq_addr),
    .cachereq_data    (cachereq_data),
    .cacheresp_val    (cacheresp_val),
    .cacheresp_rdy    (cacheresp_rdy),
    .cacheresp_type   (cacheresp_type),
    .cacheresp_opaque (cacheresp_opaque),
    .cacheresp_data   (cacheresp_data)
  );

  // expected response for the tag on the output
  assign resp_fire = cacheresp_val && cacheresp_rdy;
  assign exp_valid = pend_valid[cacheresp_opaque];
  assign exp_type  = pend_type[cacheresp_opaque];
  assign exp_data  = pend_data[cacheresp_opaque];

  // ----------------------------------------
  // assertions
  // ----------------------------------------
  a_reset_idle: assert property (@(posedge clk) !rst_n |=> (!cacheresp_val && cachereq_rdy))
    else
    begin
      errors++;
      $display("%0t: outputs not idle during or right after reset", $time);
    end

  a_resp_known: assert property (@(posedge clk) disable iff (!rst_n)
    resp_fire |-> exp_valid)
    else
    begin
      errors++;
      $display("%0t: response with opaque %h has no outstanding request",
               $time, $sampled(cacheresp_opaque));
    end

  a_resp_type: assert property (@(posedge clk) disable iff (!rst_n)
    (resp_fire && exp_valid) |-> (cacheresp_type == exp_type))
    else
    begin
      errors++;
      $display("mismatch at %0t: cacheresp_type expected %0d actual %0d",
               $time, $sampled(exp_type), $sampled(cacheresp_type));
    end

  a_resp_data: assert property (@(posedge clk) disable iff (!rst_n)
    (resp_fire && exp_valid) |-> (cacheresp_data == exp_data))
    else
    begin
      errors++;
      $display("mismatch at %0t: cacheresp_data expected %h actual %h",
               $time, $sampled(exp_data), $sampled(cacheresp_data));
    end

  // ----------------------------------------
  // reference model and outstanding table
  // ----------------------------------------
  always @(posedge clk)
  begin
    logic [9:0] idx;
    word_t      exp_word;
    if (!rst_n)
    begin
      foreach (pend_valid[i])
        pend_valid[i] <= 1'b0;
    end
    else
    begin
      if (cachereq_val && cachereq_rdy)
      begin
        idx      = cachereq_addr[11:2];
        exp_word = '0;
        if (cachereq_type == msg_read)
          exp_word = model[idx];
        else
          model[idx] = cachereq_data;
        pend_valid[cachereq_opaque] <= 1'b1;
        pend_type[cachereq_opaque]  <= cachereq_type;
        pend_data[cachereq_opaque]  <= exp_word;
      end
      // retire the tag on transfer
      if (resp_fire && exp_valid)
        pend_valid[cacheresp_opaque] <= 1'b0;
    end
  end

  // random back-pressure with rdy low about 30% of cycles
  always @(posedge clk)
    cacheresp_rdy <= bp_on ? ($urandom_range(99) >= 30) : 1'b1;

  function automatic int count_pending();
    int n;
    n = 0;
    for (int i = 0; i < 256; i++)
      if (pend_valid[i])
        n++;
    return n;
  endfunction

  // present one request and return on the edge it is taken
  task automatic send_req(input msg_type_e t, input addr_t a, input word_t d);
    while (pend_valid[next_opaque])
      @(posedge clk);
    cachereq_val    <= 1'b1;
    cachereq_type   <= t;
    cachereq_opaque <= next_opaque;
    cachereq_addr   <= a;
    cachereq_data   <= d;
    @(posedge clk);
    while (!cachereq_rdy)
      @(posedge clk);
    cachereq_val <= 1'b0;
    next_opaque  = next_opaque + 8'd1;
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial
  begin
    logic [9:0] widx;
    void'($urandom(SEED));
    rst_n           = 1'b0;
    cachereq_val    = 1'b0;
    cachereq_type   = msg_read;
    cachereq_opaque = '0;
    cachereq_addr   = '0;
    cachereq_data   = '0;
    next_opaque     = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // five words across banks 0 and 1
    for (int k = 0; k < 5; k++)
      send_req(msg_write_init, addr_t'(32'h108 + 4 * k), 32'ha5a50000 + k);
    for (int k = 0; k < 5; k++)
      send_req(msg_read, addr_t'(32'h108 + 4 * k), '0);

    // write hit on a resident word
    send_req(msg_write, 32'h110, 32'h1234abcd);
    send_req(msg_read, 32'h110, '0);

    // same bank and index with another tag
    send_req(msg_write, 32'h248, 32'h0badf00d);
    send_req(msg_write, 32'h648, 32'hfeedc0de);
    send_req(msg_read, 32'h648, '0);
    send_req(msg_read, 32'h248, '0);

    // random mix where reads only hit written words
    bp_on = 1'b1;
    for (int i = 0; i < N_RANDOM; i++)
    begin
      if (written.size() > 0 && $urandom_range(1) == 0)
      begin
        widx = written[$urandom_range(written.size() - 1)];
        send_req(msg_read, {20'h0, widx, 2'b00}, '0);
      end
      else
      begin
        widx = 10'($urandom_range(1023));
        written.push_back(widx);
        send_req(($urandom_range(1) == 0) ? msg_write : msg_write_init,
                 {20'h0, widx, 2'b00}, $urandom());
      end
    end

    // drain and then expect a quiet output
    while (count_pending() != 0)
      @(posedge clk);
    repeat (10) @(posedge clk);
    assert (!cacheresp_val)
    else
    begin
      errors++;
      $display("%0t: response traffic after the outstanding table drained", $time);
    end

    $display("checks done, errors: %0d", errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles with %0d requests outstanding",
             TIMEOUT_CYCLES, count_pending());
    $display("checks done, errors: %0d", errors + 1);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
source/cache_cfg_pkg.sv
source/cache_msg_pkg.sv
source/bank_req_if.sv
source/bank_resp_if.sv
source/cache_req_router.sv
source/cache_bank.sv
source/cache_resp_arbiter.sv
source/banked_cache_top.sv
dv/banked_cache_tb.sv

/* Makefile */
# Verilator build and run for the banked cache testbench

TOP  := banked_cache_tb
SRCS := $(shell grep -v '^+' compile.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): compile.f $(SRCS)
	verilator --binary --assert --top-module $(TOP) -f compile.f --Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
